// ==== video_stm.f ====
common/video_pkg.sv
timing/video_timing.sv
src/fetch_ctrl.sv
src/video_regs.sv
src/mono_shifter.sv
src/video_top.sv
sim/tb_clock.sv
sim/video_assertions.sv
sim/video_tb.sv

// ==== Bender.yml ====
package:
  name: video_stm

sources:
  - common/video_pkg.sv
  - timing/video_timing.sv
  - src/fetch_ctrl.sv
  - src/video_regs.sv
  - src/mono_shifter.sv
  - src/video_top.sv
  - target: test
    files:
      - sim/tb_clock.sv
      - sim/video_assertions.sv
      - sim/video_tb.sv

// ==== sim/video_tb.sv ====
// testbench for the mono video fetcher with memory model, pixel reference and checks
`timescale 1ns/1ps

module video_tb;
  import video_pkg::*;

  // small raster, 96 clocks by 8 lines
  localparam int h_act = 64, v_act = 4, h_fp = 8, h_sync = 8, h_bp = 16;
  localparam int v_fp = 1, v_sync = 2, v_bp = 1;
  localparam int v_tot = v_act + v_fp + v_sync + v_bp;
  localparam int frame_cyc = (h_act + h_fp + h_sync + h_bp) * v_tot;
  localparam int words = v_act * h_act / WORD_BITS;
  localparam int n_tests = 6;

  logic clk, ss, reg_sel, reg_rw, reg_uds, reg_lds, read, hs, vs, de_out;
  reg_addr_t reg_addr;
  vword_t reg_din, reg_dout, data;
  vaddr_t vaddr, first_addr, exp_base, mem_addr;
  pix_t video_r, video_g, video_b, exp_pix;
  int seed = 74730;
  int errors = 0, checks = 0, n_reads = 0, n_hs = 0, n_vs = 0, pix_idx = 0, f_reads;
  logic hs_q = 1'b0, vs_q = 1'b0, first_seen = 1'b0, check_on = 1'b0, exp_inv;
  logic mem_rd = 1'b0;

  tb_clock #(.period(40)) u_clk (.clk(clk));

  video_top #(.h_act(h_act), .v_act(v_act), .h_fp(h_fp), .h_sync(h_sync), .h_bp(h_bp),
    .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)) uut (
    .clk(clk), .ss(ss), .reg_sel(reg_sel), .reg_rw(reg_rw), .reg_uds(reg_uds),
    .reg_lds(reg_lds), .reg_addr(reg_addr), .reg_din(reg_din), .reg_dout(reg_dout),
    .data(data), .vaddr(vaddr), .read(read), .hs(hs), .vs(vs), .de_out(de_out),
    .video_r(video_r), .video_g(video_g), .video_b(video_b));

  // memory contents, every address bit reaches the word
  function automatic vword_t mem_word(vaddr_t a);
    return a[15:0] ^ {a[6:0], a[22:14]} ^ 16'hc35a;
  endfunction

  // pixel idx of a frame, words from base upward, msb first
  function automatic logic ref_pixel(vaddr_t base, int idx, logic inv);
    vword_t w;
    w = mem_word(base + vaddr_t'(idx / WORD_BITS));
    return w[WORD_BITS - 1 - idx % WORD_BITS] ^ inv;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic reg_write(reg_addr_t a, vword_t d);
    reg_sel = 1'b1;
    reg_rw = 1'b0;
    reg_lds = 1'b0;
    reg_addr = a;
    reg_din = d;
    @(posedge clk);
    #5;
    reg_sel = 1'b0;
    reg_rw = 1'b1;
    reg_lds = 1'b1;
  endtask

  task automatic reg_expect(reg_addr_t a, vword_t exp, string name);
    reg_sel = 1'b1;
    reg_rw = 1'b1;
    reg_lds = 1'b0;
    reg_addr = a;
    @(negedge clk);
    check_value(name, reg_dout, exp);
    @(posedge clk);
    #5;
    reg_sel = 1'b0;
    reg_lds = 1'b1;
  endtask

  // next rising vsync, bounded to two frames
  task automatic wait_vsync();
    int start;
    int n;
    start = n_vs;
    n = 0;
    while (n_vs == start && n < 2 * frame_cyc) begin
      @(posedge clk);
      #5;
      n++;
    end
    if (n_vs == start) begin
      errors++;
      $display("vsync did not arrive within two frames at %0t ns", $time);
    end
  endtask

  // one compared frame, armed in vblank and closed at the next vsync
  task automatic run_frame(vaddr_t base, logic inv);
    int r0;
    r0 = n_reads;
    exp_base = base;
    exp_inv = inv;
    pix_idx = 0;
    first_seen = 1'b0;
    check_on = 1'b1;
    wait_vsync();
    check_on = 1'b0;
    f_reads = n_reads - r0;
    check_value("de_out cycles", pix_idx, h_act * v_act);
  endtask

  task automatic report_test(int n, string name, int err0);
    $display("test %0d %s: %s", n, name, (errors == err0) ? "ok" : "failed");
  endtask

  // memory request taken on the falling edge, answered after the next rise
  always @(negedge clk) begin
    mem_rd <= read;
    mem_addr <= vaddr;
  end

  always @(posedge clk) begin
    #5;
    if (mem_rd)
      data = mem_word(mem_addr);
  end

  // pulse tallies and first read address
  always @(negedge clk) begin
    hs_q <= hs;
    vs_q <= vs;
    if (hs && !hs_q)
      n_hs++;
    if (vs && !vs_q)
      n_vs++;
    if (read) begin
      if (!first_seen)
        first_addr = vaddr;
      first_seen = 1'b1;
      n_reads++;
    end
  end

  // walks the displayed pixels of an armed frame
  always @(negedge clk) begin
    if (check_on && de_out) begin
      exp_pix = ref_pixel(exp_base, pix_idx, exp_inv) ? '1 : '0;
      check_value("video_r", video_r, exp_pix);
      check_value("video_g", video_g, exp_pix);
      check_value("video_b", video_b, exp_pix);
      pix_idx++;
    end
  end

  // four frames per test
  initial begin
    #(n_tests * 4 * frame_cyc * 40);
    $display("watchdog expired at %0t ns before the tests finished", $time);
    $display("Errors found");
    $finish;
  end

  initial begin
    int err0;
    int h0;
    int v0;
    logic [31:0] rnd;
    vaddr_t base;
    vaddr_t last;
    ss = 1'b1;
    reg_sel = 1'b0;
    reg_rw = 1'b1;
    reg_uds = 1'b1;
    reg_lds = 1'b1;
    reg_addr = '0;
    reg_din = '0;
    data = '0;
    err0 = errors;
    repeat (9) @(posedge clk);
    @(negedge clk);
    check_value("read", read, 0);
    check_value("hs", hs, 0);
    check_value("vs", vs, 0);
    check_value("de_out", de_out, 0);
    @(posedge clk);
    #5;
    ss = 1'b0;
    reg_expect(REG_BASE_HI, {8'h00, BASE_ADDR_RESET[22:15]}, "reg 0x00");
    reg_expect(REG_BASE_MID, {8'h00, BASE_ADDR_RESET[14:7]}, "reg 0x01");
    reg_expect(REG_PALETTE0, 16'h0001, "reg 0x20");
    // no fetch before the first frame boundary
    wait_vsync();
    check_value("reads before first frame", n_reads, 0);
    report_test(1, "reset state", err0);

    err0 = errors;
    run_frame(BASE_ADDR_RESET, 1'b1);
    check_value("first vaddr", first_addr, BASE_ADDR_RESET);
    report_test(2, "inverted frame from reset base", err0);

    // upper byte lanes carry noise that must be ignored
    err0 = errors;
    rnd = $random(seed);
    reg_write(REG_BASE_HI, {rnd[31:24], rnd[7:0]});
    reg_write(REG_BASE_MID, {rnd[23:16], rnd[15:8]});
    base = {rnd[7:0], rnd[15:8], 7'd0};
    run_frame(base, 1'b1);
    check_value("first vaddr", first_addr, base);
    report_test(3, "random base address", err0);

    err0 = errors;
    reg_write(REG_PALETTE0, 16'h0000);
    run_frame(base, 1'b0);
    report_test(4, "invert cleared", err0);

    // live address after the frame, low register is a byte address
    err0 = errors;
    run_frame(base, 1'b0);
    check_value("reads per frame", f_reads, words);
    last = base + vaddr_t'(words);
    reg_expect(REG_ADDR_HI, {8'h00, last[22:15]}, "reg 0x02");
    reg_expect(REG_ADDR_MID, {8'h00, last[14:7]}, "reg 0x03");
    reg_expect(REG_ADDR_LO, {8'h00, last[6:0], 1'b0}, "reg 0x04");
    report_test(5, "read count and live address", err0);

    // exactly one frame period of sync pulses
    err0 = errors;
    wait_vsync();
    h0 = n_hs;
    v0 = n_vs;
    repeat (frame_cyc) @(posedge clk);
    #5;
    check_value("hs pulses", n_hs - h0, v_tot);
    check_value("vs pulses", n_vs - v0, 1);
    report_test(6, "sync pulse counts", err0);

    errors += uut.u_fetch.u_assert.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== sim/video_assertions.sv ====
// fetch sequencer assertions on read timing, read state and frame reload
`timescale 1ns/1ps

module video_assertions (
  input logic                     clk,
  input logic                     ss,
  input logic                     read,
  input logic                     data_take,
  input logic                     fetch_win,
  input logic                     frame_end,
  input video_pkg::fetch_state_t  state,
  input video_pkg::vaddr_t        vaddr,
  input video_pkg::vaddr_t        base_addr
);
  import video_pkg::*;

  // failed assertions so far
  int fail_cnt = 0;

  // memory data is taken one clock after a single-cycle read
  take_follows_read: assert property (@(posedge clk) disable iff (ss)
    read |=> data_take && !read)
    else begin
      fail_cnt++;
      $error("data_take does not follow a single-cycle read");
    end

  // reads only while fetching inside the window
  read_in_fetch: assert property (@(posedge clk) disable iff (ss)
    read |-> state == st_fetch && $past(fetch_win))
    else begin
      fail_cnt++;
      $error("read outside st_fetch or outside the fetch window");
    end

  // address counter reloads at the frame boundary and the first read follows at once
  reload_at_frame: assert property (@(posedge clk) disable iff (ss)
    frame_end |=> read && vaddr == $past(base_addr))
    else begin
      fail_cnt++;
      $error("no first read from base_addr after frame_end");
    end

endmodule

bind fetch_ctrl video_assertions u_assert (
  .clk(clk), .ss(ss), .read(read), .data_take(data_take), .fetch_win(fetch_win),
  .frame_end(frame_end), .state(state), .vaddr(vaddr), .base_addr(base_addr)
);

// ==== sim/tb_clock.sv ====
// testbench clock source, free running from time zero
`timescale 1ns/1ps

module tb_clock #(
  parameter int period = 40
) (
  output logic clk
);
  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end
endmodule

// ==== src/video_top.sv ====
// mono video top, raster timing, word fetch, cpu registers and pixel shifter
`timescale 1ns/1ps

module video_top #(
  parameter int h_act  = video_pkg::H_ACT,
  parameter int v_act  = video_pkg::V_ACT,
  parameter int h_fp   = video_pkg::H_FP,
  parameter int h_sync = video_pkg::H_SYNC,
  parameter int h_bp   = video_pkg::H_BP,
  parameter int v_fp   = video_pkg::V_FP,
  parameter int v_sync = video_pkg::V_SYNC,
  parameter int v_bp   = video_pkg::V_BP
) (
  input  logic                  clk,
  input  logic                  ss,
  // cpu register port
  input  logic                  reg_sel,
  input  logic                  reg_rw,
  input  logic                  reg_uds,
  input  logic                  reg_lds,
  input  video_pkg::reg_addr_t  reg_addr,
  input  video_pkg::vword_t     reg_din,
  output video_pkg::vword_t     reg_dout,
  // video memory
  input  video_pkg::vword_t     data,
  output video_pkg::vaddr_t     vaddr,
  output logic                  read,
  // screen
  output logic                  hs,
  output logic                  vs,
  output logic                  de_out,
  output video_pkg::pix_t       video_r,
  output video_pkg::pix_t       video_g,
  output video_pkg::pix_t       video_b
);
  import video_pkg::*;

  logic   word_tick;
  logic   fetch_win;
  logic   de;
  logic   frame_end;
  logic   data_take;
  logic   invert;
  vaddr_t base_addr;

  // counters stay inside the timing block
  video_timing #(
    .h_act(h_act), .v_act(v_act), .h_fp(h_fp), .h_sync(h_sync),
    .h_bp(h_bp), .v_fp(v_fp), .v_sync(v_sync), .v_bp(v_bp)
  ) u_timing (
    .clk(clk), .ss(ss), .hcnt(), .vcnt(), .hs(hs), .vs(vs),
    .word_tick(word_tick), .fetch_win(fetch_win), .de(de), .frame_end(frame_end)
  );

  fetch_ctrl #(.h_act(h_act), .v_act(v_act)) u_fetch (
    .clk(clk), .ss(ss), .word_tick(word_tick), .fetch_win(fetch_win),
    .frame_end(frame_end), .base_addr(base_addr),
    .read(read), .data_take(data_take), .vaddr(vaddr)
  );

  video_regs u_regs (
    .clk(clk), .ss(ss), .reg_sel(reg_sel), .reg_rw(reg_rw), .reg_uds(reg_uds),
    .reg_lds(reg_lds), .reg_addr(reg_addr), .reg_din(reg_din), .vaddr(vaddr),
    .reg_dout(reg_dout), .base_addr(base_addr), .invert(invert)
  );

  mono_shifter u_shifter (
    .clk(clk), .ss(ss), .data_take(data_take), .word_tick(word_tick), .de(de),
    .invert(invert), .data(data), .video_r(video_r), .video_g(video_g),
    .video_b(video_b), .de_out(de_out)
  );

endmodule

// ==== src/mono_shifter.sv ====
// mono pixel path, word latch, 16-bit shift register and registered output
`timescale 1ns/1ps

module mono_shifter (
  input  logic              clk,
  input  logic              ss,
  input  logic              data_take,
  input  logic              word_tick,
  input  logic              de,
  input  logic              invert,
  input  video_pkg::vword_t data,
  output video_pkg::pix_t   video_r,
  output video_pkg::pix_t   video_g,
  output video_pkg::pix_t   video_b,
  output logic              de_out
);
  import video_pkg::*;

  vword_t data_q;
  vword_t shift_q;
  logic   pix_on;

  // holds the word until its slot comes up
  always_ff @(posedge clk) begin
    if (data_take)
      data_q <= data;
  end

  // msb first, reload once per word
  always_ff @(posedge clk) begin
    if (word_tick)
      shift_q <= data_q;
    else
      shift_q <= {shift_q[WORD_BITS-2:0], 1'b0};
  end

  // white or black, blanked outside display
  assign pix_on = de && (shift_q[WORD_BITS-1] ^ invert);

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      video_r <= '0;
      video_g <= '0;
      video_b <= '0;
      de_out  <= 1'b0;
    end else begin
      video_r <= pix_on ? '1 : '0;
      video_g <= pix_on ? '1 : '0;
      video_b <= pix_on ? '1 : '0;
      de_out  <= de;
    end
  end

endmodule

// ==== src/video_regs.sv ====
// cpu registers, base address and invert bit, with read-back mux
`timescale 1ns/1ps

module video_regs (
  input  logic                 clk,
  input  logic                 ss,
  input  logic                 reg_sel,
  input  logic                 reg_rw,
  input  logic                 reg_uds,
  input  logic                 reg_lds,
  input  video_pkg::reg_addr_t reg_addr,
  input  video_pkg::vword_t    reg_din,
  input  video_pkg::vaddr_t    vaddr,
  output video_pkg::vword_t    reg_dout,
  output video_pkg::vaddr_t    base_addr,
  output logic                 invert
);
  import video_pkg::*;

  // byte strobes are active low
  logic wr_lo;
  logic rd_lo;

  assign wr_lo = reg_sel && !reg_rw && !reg_lds;
  // upper byte holds nothing here so a read needs only the lower lane
  assign rd_lo = reg_sel && reg_rw && !reg_lds;

  // base low 7 bits are never written and stay zero from reset
  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      base_addr <= BASE_ADDR_RESET;
      invert    <= 1'b1;
    end else if (wr_lo) begin
      case (reg_addr)
        REG_BASE_HI:  base_addr[22:15] <= reg_din[7:0];
        REG_BASE_MID: base_addr[14:7]  <= reg_din[7:0];
        // palette entry 0 keeps only the invert bit
        REG_PALETTE0: invert <= reg_din[0];
        default:      base_addr <= base_addr;
      endcase
    end
  end

  // live address comes back as a byte address
  always_comb begin
    reg_dout = '0;
    if (rd_lo) begin
      case (reg_addr)
        REG_BASE_HI:  reg_dout = {8'h00, base_addr[22:15]};
        REG_BASE_MID: reg_dout = {8'h00, base_addr[14:7]};
        REG_ADDR_HI:  reg_dout = {8'h00, vaddr[22:15]};
        REG_ADDR_MID: reg_dout = {8'h00, vaddr[14:7]};
        REG_ADDR_LO:  reg_dout = {8'h00, vaddr[6:0], 1'b0};
        REG_PALETTE0: reg_dout = {15'd0, invert};
        default:      reg_dout = '0;
      endcase
    end
  end

endmodule

// ==== src/fetch_ctrl.sv ====
// fetch sequencer, issues word reads and runs the video address counter
`timescale 1ns/1ps

module fetch_ctrl #(
  parameter int h_act = video_pkg::H_ACT,
  parameter int v_act = video_pkg::V_ACT
) (
  input  logic              clk,
  input  logic              ss,
  input  logic              word_tick,
  input  logic              fetch_win,
  input  logic              frame_end,
  input  video_pkg::vaddr_t base_addr,
  output logic              read,
  output logic              data_take,
  output video_pkg::vaddr_t vaddr
);
  import video_pkg::*;

  // words fetched in one frame
  localparam vaddr_t words_per_frame = vaddr_t'(v_act * h_act / WORD_BITS);

  fetch_state_t state;
  fetch_state_t state_nxt;
  // reads issued since frame start
  vaddr_t       rd_cnt;

  always_comb begin
    state_nxt = state;
    case (state)
      st_vblank: state_nxt = st_vblank;
      st_hwait:  if (fetch_win) state_nxt = st_fetch;
      st_fetch: begin
        // window closed, last line once every word is in
        if (!fetch_win)
          state_nxt = (rd_cnt == words_per_frame) ? st_vblank : st_hwait;
      end
      default:   state_nxt = st_vblank;
    endcase
    // frame start, window opens right away on line 0
    if (frame_end)
      state_nxt = fetch_win ? st_fetch : st_hwait;
  end

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      state     <= st_vblank;
      read      <= 1'b0;
      data_take <= 1'b0;
      rd_cnt    <= '0;
      vaddr     <= BASE_ADDR_RESET;
    end else begin
      state     <= state_nxt;
      // one read per word slot while fetching
      read      <= (state_nxt == st_fetch) && word_tick;
      // memory answers one clock after the read
      data_take <= read;
      if (frame_end) begin
        rd_cnt <= '0;
        vaddr  <= base_addr;
      end else if (read) begin
        rd_cnt <= rd_cnt + vaddr_t'(1);
        vaddr  <= vaddr + vaddr_t'(1);
      end
    end
  end

endmodule

// ==== timing/video_timing.sv ====
// raster timing, pixel and line counters with sync, window and tick decode
`timescale 1ns/1ps

module video_timing #(
  parameter int h_act  = video_pkg::H_ACT,
  parameter int v_act  = video_pkg::V_ACT,
  parameter int h_fp   = video_pkg::H_FP,
  parameter int h_sync = video_pkg::H_SYNC,
  parameter int h_bp   = video_pkg::H_BP,
  parameter int v_fp   = video_pkg::V_FP,
  parameter int v_sync = video_pkg::V_SYNC,
  parameter int v_bp   = video_pkg::V_BP
) (
  input  logic            clk,
  input  logic            ss,
  output video_pkg::cnt_t hcnt,
  output video_pkg::cnt_t vcnt,
  output logic            hs,
  output logic            vs,
  output logic            word_tick,
  output logic            fetch_win,
  output logic            de,
  output logic            frame_end
);
  import video_pkg::*;

  // decode points on the counters
  localparam cnt_t h_last  = cnt_t'(h_act + h_fp + h_sync + h_bp - 1);
  localparam cnt_t v_last  = cnt_t'(v_act + v_fp + v_sync + v_bp - 1);
  localparam cnt_t hs_on   = cnt_t'(h_act + h_fp);
  localparam cnt_t hs_off  = cnt_t'(h_act + h_fp + h_sync);
  localparam cnt_t vs_on   = cnt_t'(v_act + v_fp);
  localparam cnt_t vs_off  = cnt_t'(v_act + v_fp + v_sync);
  localparam cnt_t de_on   = cnt_t'(H_PRE);
  localparam cnt_t de_off  = cnt_t'(h_act + H_PRE);
  localparam cnt_t h_act_c = cnt_t'(h_act);
  localparam cnt_t v_act_c = cnt_t'(v_act);

  cnt_t hcnt_nxt;
  cnt_t vcnt_nxt;

  // wrap at line end, line counter wraps at frame end
  always_comb begin
    hcnt_nxt = hcnt + cnt_t'(1);
    vcnt_nxt = vcnt;
    if (hcnt == h_last) begin
      hcnt_nxt = '0;
      vcnt_nxt = (vcnt == v_last) ? '0 : vcnt + cnt_t'(1);
    end
  end

  always_ff @(posedge clk or posedge ss) begin
    if (ss) begin
      hcnt <= '0;
      vcnt <= '0;
    end else begin
      hcnt <= hcnt_nxt;
      vcnt <= vcnt_nxt;
    end
  end

  // fetch strobes look one clock ahead so the registered read lands on the word
  assign word_tick = (hcnt_nxt[3:0] == 4'd0);
  assign fetch_win = (hcnt_nxt < h_act_c) && (vcnt_nxt < v_act_c);
  assign frame_end = (hcnt == h_last) && (vcnt == v_last);
  // display one word behind the fetch
  assign de = (hcnt >= de_on) && (hcnt < de_off) && (vcnt < v_act_c);
  // positive sync pulses
  assign hs = (hcnt >= hs_on) && (hcnt < hs_off);
  assign vs = (vcnt >= vs_on) && (vcnt < vs_off);

endmodule

// ==== common/video_pkg.sv ====
// video package with shared widths, register map, reset values and fetch states
package video_pkg;

  // word address into video memory
  typedef logic [22:0] vaddr_t;
  // one memory word, also one cpu register word
  typedef logic [15:0] vword_t;
  // raster counters, pixels and lines
  typedef logic [9:0] cnt_t;
  // cpu register index
  typedef logic [5:0] reg_addr_t;
  // one colour channel
  typedef logic [5:0] pix_t;

  // fetch sequencer states
  typedef enum logic [1:0] {
    st_vblank,
    st_hwait,
    st_fetch
  } fetch_state_t;

  // register map
  localparam reg_addr_t REG_BASE_HI  = 6'h00;
  localparam reg_addr_t REG_BASE_MID = 6'h01;
  localparam reg_addr_t REG_ADDR_HI  = 6'h02;
  localparam reg_addr_t REG_ADDR_MID = 6'h03;
  localparam reg_addr_t REG_ADDR_LO  = 6'h04;
  localparam reg_addr_t REG_PALETTE0 = 6'h20;

  // base address after reset, word 0x8000
  localparam vaddr_t BASE_ADDR_RESET = 23'h008000;

  // pixels per fetched word
  localparam int WORD_BITS = 16;

  // default mono raster, 640x400 at about 71 hz
  localparam int H_ACT  = 640;
  localparam int V_ACT  = 400;
  localparam int H_FP   = 24;
  localparam int H_SYNC = 40;
  localparam int H_BP   = 128;
  localparam int V_FP   = 55;
  localparam int V_SYNC = 3;
  localparam int V_BP   = 73;
  // display lags the fetch by one word
  localparam int H_PRE  = 16;

endpackage
